// File: all.f
rtl/mac_pkg.sv
rtl/mac_ctrl.sv
rtl/mac_mult_stage.sv
rtl/mac_accumulator.sv
rtl/mac_top.sv
verif/mac_tb.sv

// File: Makefile
# Verilator build and run of the MAC testbench

SIM := obj_dir/mac_sim

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module mac_tb -f all.f -o mac_sim
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: verif/mac_tb.sv
`timescale 1ns/1ps

module mac_tb;

   import mac_pkg::*;

   localparam int A_WIDTH = 18;
   localparam int B_WIDTH = 18;
   localparam int P_WIDTH = 48;

   localparam int N_CHAIN   = 20;     // Back-to-back ACC/SUB requests
   localparam int N_GAPS    = 40;     // Requests with idle gaps
   localparam int MAX_GAP   = 7;
   localparam int N_PRELOAD = 8300;   // 8192 max products reach 2**47
   localparam int N_RANDOM  = 600;

   // Upper bound of stimulus length, fixed phases fit in the 100
   localparam int STIM_CYCLES = 100 + N_GAPS * (MAX_GAP + 1) + N_PRELOAD + N_RANDOM * 4;
   localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

   localparam logic signed [A_WIDTH-1:0] A_MIN = {1'b1, {(A_WIDTH-1){1'b0}}};
   localparam logic signed [A_WIDTH-1:0] A_MAX = {1'b0, {(A_WIDTH-1){1'b1}}};
   localparam logic signed [B_WIDTH-1:0] B_MIN = {1'b1, {(B_WIDTH-1){1'b0}}};
   localparam logic signed [B_WIDTH-1:0] B_MAX = {1'b0, {(B_WIDTH-1){1'b1}}};

   logic                      clk;
   logic                      rst_n;
   logic signed [A_WIDTH-1:0] data_a;
   logic signed [B_WIDTH-1:0] data_b;
   mac_op_e                   op;
   logic                      activate_mac;
   logic signed [P_WIDTH-1:0] data_p;
   logic                      p_valid;

   logic [31:0]               rng;          // LCG state
   logic signed [P_WIDTH-1:0] model_p;      // Reference result register
   logic signed [P_WIDTH-1:0] model_next;   // Model value as seen at the request edge
   logic                      req_flag;     // High at the DUT's request edge
   logic                      req_d1;
   logic                      req_d2;       // Request indicator two edges back
   logic signed [P_WIDTH-1:0] exp_d1;
   logic signed [P_WIDTH-1:0] exp_d2;       // Expected data_p at the result edge
   logic signed [P_WIDTH-1:0] p_last;       // data_p at the previous edge
   logic signed [P_WIDTH-1:0] exp_q[$];     // Outstanding expected results
   int                        n_req;
   int                        n_res;
   int                        cycles;

   mac_top #(
      .A_WIDTH (A_WIDTH),
      .B_WIDTH (B_WIDTH),
      .P_WIDTH (P_WIDTH)
   ) u_mac_top (
      .clk          (clk),
      .rst_n        (rst_n),
      .data_a       (data_a),
      .data_b       (data_b),
      .op           (op),
      .activate_mac (activate_mac),
      .data_p       (data_p),
      .p_valid      (p_valid)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;   // 10 ns period

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic signed [63:0] expected,
                                  input logic signed [63:0] actual);
      fail_run($sformatf("error at time %0t: %s expected %0d, got %0d",
                         $time, name, expected, actual));
   endtask

   function automatic logic [31:0] next_rand();
      rng = rng * 32'd1664525 + 32'd1013904223;
      return rng;
   endfunction

   function automatic mac_op_e random_op();
      logic [31:0] r;
      r = next_rand();
      return mac_op_e'(r[31:30]);   // Top bits, the low ones cycle fast
   endfunction

   // One request at this edge, model updated from the opcode rules
   task automatic send_req(input mac_op_e o, input logic signed [A_WIDTH-1:0] a,
                           input logic signed [B_WIDTH-1:0] b);
      logic signed [P_WIDTH-1:0] ax;
      logic signed [P_WIDTH-1:0] bx;
      logic signed [P_WIDTH-1:0] prod;
      ax   = P_WIDTH'(a);   // Sign extended
      bx   = P_WIDTH'(b);
      prod = ax * bx;       // Fits, 36 significant bits
      case (o)
         MAC_LOAD: model_p = prod;
         MAC_ACC:  model_p = model_p + prod;   // Wraps at 48 bits
         MAC_SUB:  model_p = model_p - prod;
         default:  model_p = '0;
      endcase
      data_a       <= a;
      data_b       <= b;
      op           <= o;
      activate_mac <= ~activate_mac;
      req_flag     <= 1'b1;
      model_next   <= model_p;
      exp_q.push_back(model_p);
      n_req++;
      @(posedge clk);
   endtask

   task automatic random_request(input mac_op_e o);
      logic [31:0] ra;
      logic [31:0] rb;
      ra = next_rand();
      rb = next_rand();
      send_req(o, ra[31:14], rb[31:14]);
   endtask

   // No toggle, but operands and op keep moving
   task automatic idle_cycles(input int n);
      logic [31:0] r;
      repeat (n) begin
         r = next_rand();
         req_flag <= 1'b0;
         data_a   <= r[31:14];
         data_b   <= r[27:10];
         op       <= mac_op_e'(r[31:30]);
         @(posedge clk);
      end
   endtask

   // Delay line for the checks, results land two edges after the request
   always @(posedge clk) begin
      req_d1 <= req_flag;
      req_d2 <= req_d1;
      exp_d1 <= model_next;
      exp_d2 <= exp_d1;
      p_last <= data_p;
      if (rst_n && p_valid) begin
         if (exp_q.size() == 0) begin
            fail_run($sformatf("p_valid pulse at time %0t with no request pending", $time));
         end else begin
            if (data_p != exp_q[0]) begin   // Oldest outstanding result
               report_mismatch("data_p", exp_q[0], data_p);
            end
            void'(exp_q.pop_front());
            n_res++;
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         fail_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   pvalid_timing: assert property (@(posedge clk) disable iff (!rst_n)
      p_valid == req_d2)
      else report_mismatch("p_valid", $sampled(req_d2), $sampled(p_valid));

   result_value: assert property (@(posedge clk) disable iff (!rst_n)
      p_valid |-> data_p == exp_d2)
      else report_mismatch("data_p", $sampled(exp_d2), $sampled(data_p));

   result_hold: assert property (@(posedge clk) disable iff (!rst_n)
      !p_valid |-> data_p == p_last)
      else report_mismatch("data_p", $sampled(p_last), $sampled(data_p));

   initial begin
      logic [31:0] r;
      rng          = 32'hd8f878f9;
      rst_n        = 1'b0;
      data_a       = '0;
      data_b       = '0;
      op           = MAC_LOAD;
      activate_mac = 1'b0;
      model_p      = '0;
      model_next   = '0;
      req_flag     = 1'b0;
      req_d1       = 1'b0;
      req_d2       = 1'b0;
      exp_d1       = '0;
      exp_d2       = '0;
      p_last       = '0;
      n_req        = 0;
      n_res        = 0;
      cycles       = 0;

      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      idle_cycles(3);

      // Quiet after reset
      assert (p_valid == 1'b0) else report_mismatch("p_valid", 0, p_valid);
      assert (data_p == '0) else report_mismatch("data_p", 0, data_p);

      send_req(MAC_CLEAR, A_MAX, B_MAX);   // Raises activate_mac
      idle_cycles(6);                      // Held high, single pulse only

      // Corner operands
      send_req(MAC_LOAD, A_MIN, B_MIN);
      idle_cycles(2);
      send_req(MAC_LOAD, A_MIN, B_MAX);
      idle_cycles(2);
      send_req(MAC_LOAD, A_MAX, -18'sd5);
      idle_cycles(2);
      send_req(MAC_LOAD, '0, B_MIN);
      idle_cycles(2);
      send_req(MAC_LOAD, -18'sd1, -18'sd1);
      idle_cycles(2);

      // Toggle every cycle, two in flight
      for (int i = 0; i < N_CHAIN; i++) begin
         random_request((i % 2 == 1) ? MAC_SUB : MAC_ACC);
      end
      idle_cycles(3);

      random_request(MAC_CLEAR);
      random_request(MAC_ACC);        // Starts from zero
      idle_cycles(3);

      // Random gaps with wiggling inputs
      for (int i = 0; i < N_GAPS; i++) begin
         random_request(random_op());
         r = next_rand();
         idle_cycles(1 + int'(r[31:24]) % MAX_GAP);
      end

      // Large accumulations until the 48-bit result wraps
      send_req(MAC_CLEAR, '0, '0);
      repeat (N_PRELOAD) send_req(MAC_ACC, A_MIN, B_MIN);
      idle_cycles(2);

      for (int i = 0; i < N_RANDOM; i++) begin
         random_request(random_op());
         r = next_rand();
         idle_cycles(int'(r[31:30]));   // 0 keeps requests back to back
      end

      idle_cycles(4);   // Last result is due two edges after its request

      if (exp_q.size() == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         fail_run($sformatf("%0d requests but only %0d results", n_req, n_res));
      end
   end

endmodule

// File: rtl/mac_top.sv
`timescale 1ns/1ps

module mac_top #(
   parameter int A_WIDTH = 18,   // Operand A width
   parameter int B_WIDTH = 18,   // Operand B width
   parameter int P_WIDTH = 48    // Result width, at least A_WIDTH + B_WIDTH
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic signed [A_WIDTH-1:0] data_a,
   input  logic signed [B_WIDTH-1:0] data_b,
   input  mac_pkg::mac_op_e          op,
   input  logic                      activate_mac,  // Toggle to request
   output logic signed [P_WIDTH-1:0] data_p,
   output logic                      p_valid
);

   import mac_pkg::*;

   logic                      operand_en;   // Strobe from toggle detect
   mac_issue_t                issue;        // Opcode stage to accumulator
   logic signed [P_WIDTH-1:0] product;      // Multiplier to accumulator

   // Control
   // Toggle to strobe, plus the registered opcode
   mac_ctrl u_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .activate_mac (activate_mac),
      .op           (op),
      .operand_en   (operand_en),
      .issue        (issue)
   );

   // Operand registers and multiplier
   mac_mult_stage #(
      .A_WIDTH (A_WIDTH),
      .B_WIDTH (B_WIDTH),
      .P_WIDTH (P_WIDTH)
   ) u_mult (
      .clk        (clk),
      .rst_n      (rst_n),
      .operand_en (operand_en),
      .data_a     (data_a),
      .data_b     (data_b),
      .product    (product)
   );

   // Post-adder and result register
   mac_accumulator #(
      .P_WIDTH (P_WIDTH)
   ) u_acc (
      .clk     (clk),
      .rst_n   (rst_n),
      .issue   (issue),
      .product (product),
      .data_p  (data_p),     // Valid two edges after the request edge
      .p_valid (p_valid)
   );

endmodule

// File: rtl/mac_accumulator.sv
`timescale 1ns/1ps

module mac_accumulator #(
   parameter int P_WIDTH = 48
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  mac_pkg::mac_issue_t       issue,     // valid and op from the control
   input  logic signed [P_WIDTH-1:0] product,   // Sign-extended A*B
   output logic signed [P_WIDTH-1:0] data_p,
   output logic                      p_valid    // One cycle per result
);

   import mac_pkg::*;

   logic signed [P_WIDTH-1:0] p_q;      // Result register
   logic signed [P_WIDTH-1:0] p_sum;
   logic signed [P_WIDTH-1:0] p_diff;
   logic signed [P_WIDTH-1:0] p_next;   // Post-adder output
   logic                      valid_q;

   // Post-adder
   // Both paths wrap modulo 2**P_WIDTH, no saturation and no carry out
   assign p_sum  = p_q + product;
   assign p_diff = p_q - product;

   // Opcode select
   always_comb begin
      case (issue.op)
         MAC_LOAD:  p_next = product;      // Fresh start from the product
         MAC_ACC:   p_next = p_sum;
         MAC_SUB:   p_next = p_diff;
         MAC_CLEAR: p_next = '0;           // Product ignored
         default:   p_next = p_q;
      endcase
   end

   // Result register
   // Written only when a request arrives, holds through idle cycles
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         p_q <= '0;
      end else if (issue.valid) begin
         p_q <= p_next;
      end
   end

   // Result strobe, a one-cycle delayed copy of issue.valid
   // Back-to-back requests give back-to-back strobes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= issue.valid;
      end
   end

   assign data_p  = p_q;
   assign p_valid = valid_q;

endmodule

// File: rtl/mac_mult_stage.sv
`timescale 1ns/1ps

module mac_mult_stage #(
   parameter int A_WIDTH = 18,
   parameter int B_WIDTH = 18,
   parameter int P_WIDTH = 48
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      operand_en,   // Shared CE for A and B
   input  logic signed [A_WIDTH-1:0] data_a,
   input  logic signed [B_WIDTH-1:0] data_b,
   output logic signed [P_WIDTH-1:0] product      // Combinational from the registers
);

   // Full precision of a signed A x B product
   localparam int M_WIDTH = A_WIDTH + B_WIDTH;

   logic signed [A_WIDTH-1:0] a_q;
   logic signed [B_WIDTH-1:0] b_q;
   logic signed [M_WIDTH-1:0] mult;

   // Operand registers
   // Only loaded on a request, otherwise the last operands are held
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         a_q <= '0;
         b_q <= '0;
      end else if (operand_en) begin
         a_q <= data_a;
         b_q <= data_b;
      end
   end

   // Signed multiply, both sides signed so the sign bit is handled
   // Most negative times most negative still fits in M_WIDTH
   assign mult = a_q * b_q;

   // Sign extend up to the result width
   assign product = P_WIDTH'(mult);

endmodule

// File: rtl/mac_ctrl.sv
`timescale 1ns/1ps

module mac_ctrl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                activate_mac,  // Level input, every change is a request
   input  mac_pkg::mac_op_e    op,
   output logic                operand_en,    // Operand register enable
   output mac_pkg::mac_issue_t issue          // To the accumulator
);

   import mac_pkg::*;

   logic       act_q;      // activate_mac as sampled at the previous edge
   mac_issue_t issue_d;    // Next value of the opcode stage
   mac_issue_t issue_q;

   // Toggle detect
   // Any difference between the live level and the last sample is one
   // request, so a change on every cycle still gives one strobe each
   assign operand_en = activate_mac ^ act_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         act_q <= 1'b0;
      end else begin
         act_q <= activate_mac;    // Strobe drops after one cycle
      end
   end

   // Opcode stage
   // valid follows the strobe, op is only taken on a request so an idle
   // cycle keeps the last opcode
   always_comb begin
      issue_d.valid = operand_en;
      issue_d.op    = issue_q.op;
      if (operand_en) begin
         issue_d.op = op;          // Capture with the operands
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_q.valid <= 1'b0;
         issue_q.op    <= MAC_LOAD;
      end else begin
         issue_q <= issue_d;
      end
   end

   assign issue = issue_q;

   // Pipeline relation at the ports
   //   edge E1: operands and issue captured while operand_en is high
   //   edge E2: accumulator writes data_p and raises p_valid
   // Nothing here stalls, every toggle makes it through

endmodule

// File: rtl/mac_pkg.sv
package mac_pkg;

   // Operation applied to the 48-bit result register
   // Two bits wide, the same encoding at every stage
   typedef enum logic [1:0] {
      MAC_LOAD  = 2'd0,   // P <= A*B
      MAC_ACC   = 2'd1,   // P <= P + A*B
      MAC_SUB   = 2'd2,   // P <= P - A*B
      MAC_CLEAR = 2'd3    // P <= 0, operands don't matter
   } mac_op_e;

   // Opcode stage register
   // Sits in step with the operand registers of the multiplier, so op
   // and valid arrive at the accumulator in the same cycle as the
   // product they belong to
   typedef struct packed {
      logic    valid;     // One cycle per accepted toggle
      mac_op_e op;        // Latched alongside the operands
   } mac_issue_t;

   // Layout is valid in bit 2, op in bits 1:0

endpackage
